// ==== filelist.f ====
rtl/cpu16_pkg.sv
rtl/alu.sv
rtl/register_file.sv
rtl/instr_decoder.sv
rtl/execute_unit.sv
rtl/axil_slave.sv
rtl/cpu16_top.sv
testbench/cpu16_assertions.sv
testbench/cpu16_tb.sv

// ==== rtl/alu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 16-bit combinational ALU with zero, negative and carry flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module alu (
    input  logic [cpu16_pkg::data_width-1:0] a,       // operand a
    input  logic [cpu16_pkg::data_width-1:0] b,       // operand b or imm
    input  cpu16_pkg::alu_op_e               op,
    output logic [cpu16_pkg::data_width-1:0] result,
    output cpu16_pkg::alu_flags_t            flags
);

    logic [cpu16_pkg::data_width:0] res_ext;  // 17 bits, msb is carry out
    logic                           arith;    // add or sub

    always_comb begin
        case (op)
            cpu16_pkg::op_add: res_ext = {1'b0, a} + {1'b0, b};
            cpu16_pkg::op_sub: res_ext = {1'b0, a} - {1'b0, b};  // borrow in bit 16
            cpu16_pkg::op_and: res_ext = {1'b0, a & b};
            cpu16_pkg::op_or:  res_ext = {1'b0, a | b};
            cpu16_pkg::op_xor: res_ext = {1'b0, a ^ b};
            cpu16_pkg::op_sll: res_ext = {1'b0, a << b[3:0]};
            cpu16_pkg::op_srl: res_ext = {1'b0, a >> b[3:0]};
            cpu16_pkg::op_sla: res_ext = {1'b0, a <<< b[3:0]};   // same as sll
            cpu16_pkg::op_sra: res_ext = {1'b0, $signed(a) >>> b[3:0]};  // sign fill
            cpu16_pkg::op_ldi: res_ext = {1'b0, b};
            cpu16_pkg::op_mov: res_ext = {1'b0, a};
            default:           res_ext = '0;  // undefined op
        endcase
    end

    assign arith = (op == cpu16_pkg::op_add) || (op == cpu16_pkg::op_sub);

    assign result         = res_ext[cpu16_pkg::data_width-1:0];
    assign flags.zero     = (result == '0);
    assign flags.negative = result[cpu16_pkg::data_width-1];
    assign flags.carry    = arith & res_ext[cpu16_pkg::data_width];  // cleared otherwise

endmodule

// ==== rtl/axil_slave.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite slave: instruction and status writes, register and status
// reads, one outstanding transaction per channel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module axil_slave (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic [cpu16_pkg::axi_addr_width-1:0] awaddr,
    input  logic                                 awvalid,
    output logic                                 awready,
    input  logic [cpu16_pkg::axi_data_width-1:0] wdata,
    input  logic [3:0]                           wstrb,    // full-word writes only
    input  logic                                 wvalid,
    output logic                                 wready,
    output logic [1:0]                           bresp,
    output logic                                 bvalid,
    input  logic                                 bready,
    input  logic [cpu16_pkg::axi_addr_width-1:0] araddr,
    input  logic                                 arvalid,
    output logic                                 arready,
    output logic [cpu16_pkg::axi_data_width-1:0] rdata,
    output logic [1:0]                           rresp,
    output logic                                 rvalid,
    input  logic                                 rready,
    output logic                                 issue,
    output cpu16_pkg::instr_t                    instr,
    output logic                                 clear_illegal,
    output logic [cpu16_pkg::reg_idx_width-1:0]  rd_idx,
    input  logic [cpu16_pkg::data_width-1:0]     rd_data,
    input  cpu16_pkg::status_t                   status
);

    logic wr_accept, rd_accept, wr_hit;
    logic rd_hit_reg, rd_hit_status;

    // write channel: aw and w taken together while no response is pending
    assign wr_accept     = awvalid & wvalid & ~bvalid;
    assign awready       = wr_accept;
    assign wready        = wr_accept;
    assign issue         = wr_accept & (awaddr == cpu16_pkg::addr_instr);
    assign clear_illegal = wr_accept & (awaddr == cpu16_pkg::addr_status);
    assign wr_hit        = issue | clear_illegal;
    assign instr         = cpu16_pkg::instr_t'(wdata[cpu16_pkg::data_width-1:0]);

    // read channel
    assign arready       = ~rvalid;
    assign rd_accept     = arvalid & arready;
    assign rd_hit_reg    = (araddr[7:5] == cpu16_pkg::addr_reg_base[7:5]) && (araddr[1:0] == 2'b00);
    assign rd_hit_status = (araddr == cpu16_pkg::addr_status);
    assign rd_idx        = araddr[4:2];  // 0x40 + 4n

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_accept)   bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;
            if (rd_accept)   rvalid <= 1'b1;
            else if (rready) rvalid <= 1'b0;
        end
    end

    // response payload, held until the handshake completes
    always_ff @(posedge clk) begin
        if (wr_accept) bresp <= wr_hit ? cpu16_pkg::axi_resp_okay : cpu16_pkg::axi_resp_slverr;
        if (rd_accept) begin
            rresp <= (rd_hit_reg || rd_hit_status) ? cpu16_pkg::axi_resp_okay
                                                   : cpu16_pkg::axi_resp_slverr;
            if (rd_hit_reg)         rdata <= cpu16_pkg::axi_data_width'(rd_data);
            else if (rd_hit_status) rdata <= cpu16_pkg::axi_data_width'(status);  // upper 0
            else                    rdata <= '0;  // unmapped
        end
    end

endmodule

// ==== rtl/cpu16_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cpu16 shared definitions: widths, opcodes, instruction and control
// structs, flag/status layout and the AXI4-Lite register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cpu16_pkg;

    localparam int data_width     = 16;   // register / operand width
    localparam int reg_count      = 8;
    localparam int reg_idx_width  = 3;
    localparam int imm_width      = 9;    // ldi immediate, sign-extended
    localparam int axi_addr_width = 8;
    localparam int axi_data_width = 32;

    // alu opcodes, reference encodings
    typedef enum logic [3:0] {
        op_add = 4'b0000,
        op_sub = 4'b0001,
        op_and = 4'b0010,
        op_or  = 4'b0011,
        op_xor = 4'b0100,
        op_sll = 4'b0101,
        op_srl = 4'b0110,
        op_sla = 4'b0111,
        op_sra = 4'b1000,
        op_ldi = 4'b1100,   // pass b
        op_mov = 4'b1101    // pass a
    } alu_op_e;

    typedef struct packed {
        alu_op_e                  op;     // 15:12
        logic [reg_idx_width-1:0] rd;     // 11:9
        logic [reg_idx_width-1:0] rs_a;   // 8:6
        logic [reg_idx_width-1:0] rs_b;   // 5:3
        logic [2:0]               spare;  // 2:0, low imm bits for ldi
    } instr_t;

    typedef struct packed {
        alu_op_e                  op;
        logic [reg_idx_width-1:0] rd;
        logic [reg_idx_width-1:0] rs_a;
        logic [reg_idx_width-1:0] rs_b;
        logic                     use_imm;  // operand b from immediate
        logic [data_width-1:0]    imm;
        logic                     legal;
    } exec_ctrl_t;

    // field order gives bus bits 2:0 = carry, negative, zero
    typedef struct packed {
        logic carry;
        logic negative;
        logic zero;
    } alu_flags_t;

    typedef struct packed {
        logic       illegal;  // bit 3, sticky
        alu_flags_t flags;    // bits 2:0
    } status_t;

    localparam logic [axi_addr_width-1:0] addr_instr    = 8'h00;
    localparam logic [axi_addr_width-1:0] addr_status   = 8'h04;
    localparam logic [axi_addr_width-1:0] addr_reg_base = 8'h40;

    localparam logic [1:0] axi_resp_okay   = 2'b00;
    localparam logic [1:0] axi_resp_slverr = 2'b10;

endpackage

// ==== rtl/cpu16_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cpu16 top: AXI4-Lite slave in front of the execute unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cpu16_top (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic [cpu16_pkg::axi_addr_width-1:0] awaddr,
    input  logic                                 awvalid,
    output logic                                 awready,
    input  logic [cpu16_pkg::axi_data_width-1:0] wdata,
    input  logic [3:0]                           wstrb,
    input  logic                                 wvalid,
    output logic                                 wready,
    output logic [1:0]                           bresp,
    output logic                                 bvalid,
    input  logic                                 bready,
    input  logic [cpu16_pkg::axi_addr_width-1:0] araddr,
    input  logic                                 arvalid,
    output logic                                 arready,
    output logic [cpu16_pkg::axi_data_width-1:0] rdata,
    output logic [1:0]                           rresp,
    output logic                                 rvalid,
    input  logic                                 rready
);

    logic                                issue, clear_illegal;
    cpu16_pkg::instr_t                   instr;
    logic [cpu16_pkg::reg_idx_width-1:0] rd_idx;
    logic [cpu16_pkg::data_width-1:0]    rd_data;
    cpu16_pkg::status_t                  status;

    axil_slave i_axil (.*);  // bus side plus execute-unit handshake

    execute_unit i_exec (
        .clk           (clk),
        .arst_n        (arst_n),
        .issue         (issue),
        .instr         (instr),
        .clear_illegal (clear_illegal),
        .rd_idx        (rd_idx),
        .rd_data       (rd_data),
        .status        (status)
    );

endmodule

// ==== rtl/execute_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-cycle execute stage: decode, register read, ALU, write-back,
// flag and sticky-illegal state
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module execute_unit (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                issue,          // one-cycle strobe
    input  cpu16_pkg::instr_t                   instr,
    input  logic                                clear_illegal,
    input  logic [cpu16_pkg::reg_idx_width-1:0] rd_idx,         // host read index
    output logic [cpu16_pkg::data_width-1:0]    rd_data,
    output cpu16_pkg::status_t                  status
);

    cpu16_pkg::exec_ctrl_t            ctrl;
    cpu16_pkg::alu_flags_t            alu_flags;
    cpu16_pkg::alu_flags_t            flags_q;
    logic                             illegal_q;
    logic [cpu16_pkg::data_width-1:0] src_a, src_b, op_b, alu_res;
    logic                             wb_en;

    instr_decoder i_dec (.instr(instr), .ctrl(ctrl));

    register_file i_rf (
        .clk       (clk),
        .arst_n    (arst_n),
        .we        (wb_en),
        .wr_idx    (ctrl.rd),
        .wr_data   (alu_res),
        .rd_a_idx  (ctrl.rs_a),
        .rd_a_data (src_a),
        .rd_b_idx  (ctrl.rs_b),
        .rd_b_data (src_b),
        .rd_c_idx  (rd_idx),
        .rd_c_data (rd_data)
    );

    assign op_b = ctrl.use_imm ? ctrl.imm : src_b;  // ldi takes the immediate

    alu i_alu (.a(src_a), .b(op_b), .op(ctrl.op), .result(alu_res), .flags(alu_flags));

    assign wb_en = issue & ctrl.legal;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags_q   <= '0;
            illegal_q <= 1'b0;
        end else begin
            if (wb_en) flags_q <= alu_flags;             // every legal op updates flags
            if (issue && !ctrl.legal) illegal_q <= 1'b1; // wins over clear
            else if (clear_illegal)   illegal_q <= 1'b0;
        end
    end

    assign status = '{illegal: illegal_q, flags: flags_q};

endmodule

// ==== rtl/instr_decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction decoder: register fields, operand select, immediate
// and opcode legality
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module instr_decoder (
    input  cpu16_pkg::instr_t     instr,
    output cpu16_pkg::exec_ctrl_t ctrl
);

    logic [cpu16_pkg::imm_width-1:0] imm_raw;  // bits 8:0 of the word

    assign imm_raw = {instr.rs_a, instr.rs_b, instr.spare};

    assign ctrl.op      = instr.op;
    assign ctrl.rd      = instr.rd;
    assign ctrl.rs_a    = instr.rs_a;
    assign ctrl.rs_b    = instr.rs_b;
    assign ctrl.use_imm = (instr.op == cpu16_pkg::op_ldi);
    assign ctrl.imm     = {{(cpu16_pkg::data_width - cpu16_pkg::imm_width)
                            {imm_raw[cpu16_pkg::imm_width-1]}}, imm_raw};  // sign extend

    // only the eleven defined opcodes
    always_comb begin
        case (instr.op)
            cpu16_pkg::op_add,
            cpu16_pkg::op_sub,
            cpu16_pkg::op_and,
            cpu16_pkg::op_or,
            cpu16_pkg::op_xor,
            cpu16_pkg::op_sll,
            cpu16_pkg::op_srl,
            cpu16_pkg::op_sla,
            cpu16_pkg::op_sra,
            cpu16_pkg::op_ldi,
            cpu16_pkg::op_mov: ctrl.legal = 1'b1;
            default:           ctrl.legal = 1'b0;  // 1001..1011, 1110, 1111
        endcase
    end

endmodule

// ==== rtl/register_file.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// eight 16-bit registers, three combinational read ports, one write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module register_file (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                we,
    input  logic [cpu16_pkg::reg_idx_width-1:0] wr_idx,
    input  logic [cpu16_pkg::data_width-1:0]    wr_data,
    input  logic [cpu16_pkg::reg_idx_width-1:0] rd_a_idx,
    output logic [cpu16_pkg::data_width-1:0]    rd_a_data,
    input  logic [cpu16_pkg::reg_idx_width-1:0] rd_b_idx,
    output logic [cpu16_pkg::data_width-1:0]    rd_b_data,
    input  logic [cpu16_pkg::reg_idx_width-1:0] rd_c_idx,  // host read port
    output logic [cpu16_pkg::data_width-1:0]    rd_c_data
);

    logic [cpu16_pkg::data_width-1:0] regs [cpu16_pkg::reg_count];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < cpu16_pkg::reg_count; i++) begin
                regs[i] <= '0;  // registers start at zero
            end
        end else if (we) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // no write-to-read forwarding
    assign rd_a_data = regs[rd_a_idx];
    assign rd_b_data = regs[rd_b_idx];
    assign rd_c_data = regs[rd_c_idx];

endmodule

// ==== testbench/cpu16_assertions.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite response channel protocol checks, bound into cpu16_top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cpu16_assertions (
    input logic        clk,
    input logic        arst_n,
    input logic        awready,
    input logic        bvalid,
    input logic        bready,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata,
    input logic [1:0]  rresp
);

    int violations = 0;  // failed assertion count

    function automatic void flag_violation(input string what);
        $error("%s", what);
        violations++;
    endfunction

    // write response held until taken
    assert property (@(posedge clk) disable iff (!arst_n) bvalid && !bready |=> bvalid)
        else flag_violation("bvalid dropped before bready");
    assert property (@(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else flag_violation("read response changed while rvalid waited");
    // accept gives bvalid next cycle, no second write taken meanwhile
    assert property (@(posedge clk) disable iff (!arst_n) awready |=> bvalid && !awready)
        else flag_violation("write accept without a single pending response");
    assert property (@(posedge clk) $rose(arst_n) |-> !bvalid && !rvalid)
        else flag_violation("response valid right after reset");

endmodule

bind cpu16_top cpu16_assertions i_assertions (
    .clk, .arst_n, .awready, .bvalid, .bready, .rvalid, .rready, .rdata, .rresp
);

// ==== testbench/cpu16_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cpu16 testbench: vector-driven AXI4-Lite master with random
// response back-pressure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cpu16_tb;

    localparam int vec_count    = 36;
    localparam int reset_cycles = 10;
    localparam int cycle_limit  = vec_count * 16 + reset_cycles;  // 16 per transfer

    typedef struct packed {
        logic [3:0]  kind;   // 0 write, 1 read
        logic [7:0]  addr;
        logic [31:0] data;   // write data
        logic [3:0]  resp;   // expected bresp or rresp
        logic [31:0] rdata;  // expected read data
    } vector_t;

    logic        clk, arst_n;
    logic [7:0]  awaddr, araddr;
    logic [31:0] wdata, rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic [79:0] vec_mem [vec_count];
    vector_t     vec;
    integer      seed;
    int          cycles;

    cpu16_top i_dut (.*);

    always #5 clk = ~clk;  // 10 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles without finishing the vectors", cycles);
            $display("Simulation failed");
            $fatal(1, "run stopped by timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // 0 to 3 cycles before the master takes a response
    task automatic stall_response();
        repeat ($unsigned($random(seed)) % 4) @(posedge clk);
    endtask

    task automatic write_word(input vector_t v);
        awaddr  <= v.addr;
        wdata   <= v.data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(posedge clk); while (!(awready && wready));  // accept cycle
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        stall_response();
        bready <= 1'b1;
        do @(posedge clk); while (!bvalid);
        bready <= 1'b0;
        check_value("bresp", 32'(bresp), 32'(v.resp));
    endtask

    task automatic read_word(input vector_t v);
        araddr  <= v.addr;
        arvalid <= 1'b1;
        do @(posedge clk); while (!arready);
        arvalid <= 1'b0;
        stall_response();
        rready <= 1'b1;
        do @(posedge clk); while (!rvalid);  // sampled before the handshake clears it
        rready <= 1'b0;
        check_value("rresp", 32'(rresp), 32'(v.resp));
        check_value("rdata", rdata, v.rdata);
    endtask

    initial begin
        seed    = 32'hd1fd_da54;
        cycles  = 0;
        clk     = 1'b0;
        arst_n  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 4'hf;  // full-word writes
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        $readmemh("testbench/cpu16_vectors.txt", vec_mem);
        repeat (reset_cycles) @(posedge clk);
        check_value("arready", 32'(arready), 32'h1);
        arst_n <= 1'b1;
        for (int i = 0; i < vec_count; i++) begin
            vec = vector_t'(vec_mem[i]);
            case (vec.kind)
                4'h0:    write_word(vec);
                4'h1:    read_word(vec);
                default: begin
                    $display("vector %0d has no valid transaction kind", i);
                    $display("Simulation failed");
                    $fatal(1, "bad vector file");
                end
            endcase
        end
        if (i_dut.i_assertions.violations == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("protocol assertions failed %0d times", i_dut.i_assertions.violations);
            $display("Simulation failed");
            $fatal(1, "protocol assertion failures");
        end
    end

endmodule

// ==== testbench/cpu16_vectors.txt ====
// kind (0 write, 1 read) _ address _ write data _ expected resp _ expected read data
// ldi r1..r4, then alu ops, illegal opcode, status clear, unmapped accesses
0_00_0000c203_0_00000000
0_00_0000c5fd_0_00000000
0_00_0000c6ff_0_00000000
0_00_0000c900_0_00000000
1_48_00000000_0_0000fffd
1_50_00000000_0_0000ff00
0_00_00000a50_0_00000000
1_54_00000000_0_00000000
1_04_00000000_0_00000005
0_00_00001e58_0_00000000
1_5c_00000000_0_0000ff04
1_04_00000000_0_00000006
0_00_00002a98_0_00000000
1_54_00000000_0_000000fd
1_04_00000000_0_00000000
0_00_00003c60_0_00000000
1_58_00000000_0_0000ff03
0_00_00004e98_0_00000000
1_5c_00000000_0_0000ff02
0_00_0000d100_0_00000000
1_40_00000000_0_0000ff00
0_00_00005ac8_0_00000000
1_54_00000000_0_000007f8
0_00_00006d08_0_00000000
1_58_00000000_0_00001fe0
0_00_00007e88_0_00000000
1_5c_00000000_0_0000ffe8
0_00_00008d08_0_00000000
1_58_00000000_0_0000ffe0
0_00_00009fff_0_00000000
1_5c_00000000_0_0000ffe8
1_04_00000000_0_0000000a
0_04_00000000_0_00000000
1_04_00000000_0_00000002
0_08_00001234_2_00000000
1_60_00000000_2_00000000
